// ==== build.f ====
hw/dtm_pkg.sv
hw/tap5_fsm.sv
hw/tap2_sequencer.sv
hw/tap2_frame.sv
hw/dtm_ctrl_top.sv
tb/dtm_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the debug transport controller testbench

TOP = dtm_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# the run passes only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== tb/dtm_ctrl_tb.sv ====
/*
 * testbench for the debug transport control core
 *   random four-wire TMS walk against a TAP state model
 *   two-wire IR writes, DR reads and a DR write
 *   hard reset in mid packet and mode exclusion
 */
`timescale 1ns/1ps
`default_nettype none

module dtm_ctrl_tb
    import dtm_pkg::*;
();

    localparam int MAX_CYCLES = 4000;  // stimulus is well under a thousand cycles

    logic                tclk;
    logic                trst_b;
    logic                dmi_hard_reset_i;
    logic                tap_en_i;
    logic                jtag2_sel_i;
    logic                tms_i;
    logic                dmi_short_mode_i;
    logic [IR_WIDTH-1:0] chain_ir_i;
    logic                tdo_en_o;
    logic                tms_oe_o;
    chain_ctrl_t         chain_ctrl_o;
    logic                shift_par_o;
    logic                shift_sync_o;

    // two-wire expectations for the current cycle as set by the driver
    chain_ctrl_t exp2_ctrl;
    logic        exp_par;
    logic        exp_sync;
    logic        exp_oe;

    tap5_state_e model_state;
    chain_ctrl_t exp_chain;
    logic        exp_tdo;
    string       test_name;
    int          err_cnt;
    int          checked_cnt;
    int          cycle_cnt;
    int          shift_seen;
    int          cap_seen;
    int          upd_seen;
    logic [63:0] data;
    int          i;

    dtm_ctrl_top dtm_ctrl_top_inst (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .tap_en_i         (tap_en_i),
        .jtag2_sel_i      (jtag2_sel_i),
        .tms_i            (tms_i),
        .dmi_short_mode_i (dmi_short_mode_i),
        .chain_ir_i       (chain_ir_i),
        .tdo_en_o         (tdo_en_o),
        .tms_oe_o         (tms_oe_o),
        .chain_ctrl_o     (chain_ctrl_o),
        .shift_par_o      (shift_par_o),
        .shift_sync_o     (shift_sync_o)
    );

    always #20 tclk = ~tclk;

    // ====================
    // reference model
    // ====================
    function automatic tap5_state_e next_tap_state(input tap5_state_e s, input logic tms,
                                                   input logic en, input logic hold);
        tap5_state_e nxt;
        case (s)
            TAP5_RESET:     nxt = (en && !tms) ? TAP5_IDLE : TAP5_RESET;
            TAP5_IDLE:      nxt = tms ? TAP5_SEL_DR    : TAP5_IDLE;
            TAP5_SEL_DR:    nxt = tms ? TAP5_SEL_IR    : TAP5_CAPT_DR;
            TAP5_CAPT_DR:   nxt = tms ? TAP5_EXIT1_DR  : TAP5_SHIFT_DR;
            TAP5_SHIFT_DR:  nxt = tms ? TAP5_EXIT1_DR  : TAP5_SHIFT_DR;
            TAP5_EXIT1_DR:  nxt = tms ? TAP5_UPDATE_DR : TAP5_PAUSE_DR;
            TAP5_PAUSE_DR:  nxt = tms ? TAP5_EXIT2_DR  : TAP5_PAUSE_DR;
            TAP5_EXIT2_DR:  nxt = tms ? TAP5_UPDATE_DR : TAP5_SHIFT_DR;
            TAP5_UPDATE_DR: nxt = tms ? TAP5_SEL_DR    : TAP5_IDLE;
            TAP5_SEL_IR:    nxt = tms ? TAP5_RESET     : TAP5_CAPT_IR;
            TAP5_CAPT_IR:   nxt = tms ? TAP5_EXIT1_IR  : TAP5_SHIFT_IR;
            TAP5_SHIFT_IR:  nxt = tms ? TAP5_EXIT1_IR  : TAP5_SHIFT_IR;
            TAP5_EXIT1_IR:  nxt = tms ? TAP5_UPDATE_IR : TAP5_PAUSE_IR;
            TAP5_PAUSE_IR:  nxt = tms ? TAP5_EXIT2_IR  : TAP5_PAUSE_IR;
            TAP5_EXIT2_IR:  nxt = tms ? TAP5_UPDATE_IR : TAP5_SHIFT_IR;
            TAP5_UPDATE_IR: nxt = tms ? TAP5_SEL_DR    : TAP5_IDLE;
            default:        nxt = TAP5_RESET;
        endcase
        return hold ? TAP5_RESET : nxt;    // hard reset or two-wire mode
    endfunction

    function automatic chain_ctrl_t decode_strobes(input tap5_state_e s);
        chain_ctrl_t c;
        c.capture_ir = (s == TAP5_CAPT_IR);
        c.capture_dr = (s == TAP5_CAPT_DR);
        c.shift_ir   = (s == TAP5_SHIFT_IR);
        c.shift_dr   = (s == TAP5_SHIFT_DR);
        c.update_ir  = (s == TAP5_UPDATE_IR);
        c.update_dr  = (s == TAP5_UPDATE_DR);
        return c;
    endfunction

    // data bits per packet; bit 0 of sel is sent first
    function automatic int expected_len(input logic [1:0] sel, input logic [IR_WIDTH-1:0] ir,
                                        input logic short_mode);
        int len;
        if (sel == 2'b10)
            len = 5;
        else if (sel != 2'b11)
            len = 1;                       // unknown select
        else if (ir == IR_DMI)
            len = short_mode ? 34 : 50;
        else if (ir == IR_IDCODE || ir == IR_DTMCS)
            len = 32;
        else
            len = 1;                       // dmi access and unlisted codes
        return len;
    endfunction

    function automatic logic parity_passes(input logic [63:0] bits, input int len,
                                           input logic par);
        int ones;
        int k;
        ones = int'(par);
        for (k = 0; k < len; k++)
            ones = ones + int'(bits[k]);
        return (ones % 2) == 1;            // odd count of ones
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        err_cnt++;
        $display("** Error %s: %s expected %0h, actual %0h",
                 test_name, what, exp_val, act_val);
    endtask

    // ====================
    // checker just before each rising edge
    // ====================
    always begin
        @(posedge tclk);
        #35;
        exp_chain = chain_ctrl_t'(decode_strobes(model_state) | exp2_ctrl);
        exp_tdo   = !dmi_hard_reset_i &&
                    (model_state == TAP5_SHIFT_IR || model_state == TAP5_SHIFT_DR);
        checked_cnt++;
        if (chain_ctrl_o !== exp_chain)
            report_mismatch("chain_ctrl_o", 64'(exp_chain), 64'(chain_ctrl_o));
        if (tdo_en_o !== exp_tdo)
            report_mismatch("tdo_en_o", 64'(exp_tdo), 64'(tdo_en_o));
        if (tms_oe_o !== exp_oe)
            report_mismatch("tms_oe_o", 64'(exp_oe), 64'(tms_oe_o));
        if (shift_par_o !== exp_par)
            report_mismatch("shift_par_o", 64'(exp_par), 64'(shift_par_o));
        if (shift_sync_o !== exp_sync)
            report_mismatch("shift_sync_o", 64'(exp_sync), 64'(shift_sync_o));
        if (chain_ctrl_o.shift_ir || chain_ctrl_o.shift_dr)
            shift_seen++;
        if (chain_ctrl_o.capture_ir || chain_ctrl_o.capture_dr)
            cap_seen++;
        if (chain_ctrl_o.update_ir || chain_ctrl_o.update_dr)
            upd_seen++;
        // model follows the inputs the DUT sees at the next edge
        if (!trst_b)
            model_state = TAP5_RESET;
        else
            model_state = next_tap_state(model_state, tms_i, tap_en_i,
                                         jtag2_sel_i || dmi_hard_reset_i);
    end

    always @(posedge tclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt == MAX_CYCLES);
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // ====================
    // stimulus tasks
    // ====================
    task automatic drive_cycle(input logic tms, input logic hard, input chain_ctrl_t ctrl,
                               input logic par, input logic sync, input logic oe);
        @(posedge tclk);
        #2;
        tms_i            = tms;
        dmi_hard_reset_i = hard;
        exp2_ctrl        = ctrl;
        exp_par          = par;
        exp_sync         = sync;
        exp_oe           = oe;
    endtask

    // tap enable drops and hard reset pulses now and then
    task automatic walk_tap5(input int n);
        int k;
        @(posedge tclk);
        #2;
        jtag2_sel_i = 1'b0;
        for (k = 0; k < n; k++) begin
            drive_cycle(($urandom % 3) == 0, ($urandom % 32) == 0, '0,
                        1'b0, 1'b0, 1'b0); // mostly low
            tap_en_i = ($urandom % 4) != 0;
        end
        tap_en_i         = 1'b1;
        dmi_hard_reset_i = 1'b0;
    endtask

    task automatic enter_two_wire();
        @(posedge tclk);
        #2;
        jtag2_sel_i = 1'b1;
        tms_i       = 1'b1;                // idle high moves reset to start
        drive_cycle(1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // one packet from the start phase; abort_at >= 0 pulses hard reset in that data bit
    task automatic send_packet(input logic rd, input logic [1:0] sel, input logic [63:0] bits,
                               input logic par, input int abort_at);
        int          len;
        int          k;
        logic        ok;
        logic        known;
        chain_ctrl_t cap;
        chain_ctrl_t shf;
        chain_ctrl_t upd;
        len   = expected_len(sel, chain_ir_i, dmi_short_mode_i);
        ok    = parity_passes(bits, len, par);
        known = (sel == 2'b10) || (sel == 2'b11);
        cap   = '0;
        shf   = '0;
        upd   = '0;
        cap.capture_ir = rd && sel == 2'b10;
        cap.capture_dr = rd && sel == 2'b11;
        shf.shift_ir   = (sel == 2'b10);
        shf.shift_dr   = (sel == 2'b11);
        upd.update_ir  = !rd && ok && sel == 2'b10;
        upd.update_dr  = !rd && ok && sel == 2'b11;
        shift_seen = 0;
        cap_seen   = 0;
        upd_seen   = 0;
        drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0);     // start bit
        drive_cycle(rd, 1'b0, '0, 1'b0, 1'b0, 1'b0);       // rw
        drive_cycle(sel[0], 1'b0, '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(sel[1], 1'b0, '0, 1'b0, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, cap, 1'b0, 1'b0, 1'b0);    // trn1
        if (rd)
            drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b1); // sync
        for (k = 0; k < len; k++) begin
            drive_cycle(bits[k], k == abort_at, shf, 1'b0, 1'b0, rd);
            if (k == abort_at) begin
                drive_cycle(1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
                return;
            end
        end
        drive_cycle(par, 1'b0, '0, 1'b1, 1'b0, rd);        // parity
        drive_cycle(1'b1, 1'b0, upd, 1'b0, 1'b0, rd);      // trn2
        drive_cycle(1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);     // back in start
        if (shift_seen != (known ? len : 0))
            report_mismatch("shift cycles", 64'(known ? len : 0), 64'(shift_seen));
        if (cap_seen != int'(rd && known))
            report_mismatch("capture pulses", 64'(rd && known), 64'(cap_seen));
        if (upd_seen != int'(upd != '0))
            report_mismatch("update pulses", 64'(upd != '0), 64'(upd_seen));
    endtask

    task automatic read_dr(input logic [IR_WIDTH-1:0] ir, input logic short_mode);
        chain_ir_i       = ir;
        dmi_short_mode_i = short_mode;
        send_packet(1'b1, 2'b11, {$urandom, $urandom}, 1'($urandom), -1);
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        void'($urandom(32'h8544));
        tclk             = 1'b0;
        trst_b           = 1'b0;
        dmi_hard_reset_i = 1'b0;
        tap_en_i         = 1'b1;
        jtag2_sel_i      = 1'b0;
        tms_i            = 1'b1;
        dmi_short_mode_i = 1'b0;
        chain_ir_i       = IR_IDCODE;
        exp2_ctrl        = '0;
        exp_par          = 1'b0;
        exp_sync         = 1'b0;
        exp_oe           = 1'b0;
        model_state      = TAP5_RESET;
        test_name        = "reset";
        repeat (16) @(posedge tclk);
        #2;
        trst_b = 1'b1;

        test_name = "tap5_walk";
        walk_tap5(300);

        test_name = "tap2_ir_write";
        enter_two_wire();
        for (i = 0; i < 4; i++) begin
            data = 64'($urandom);
            send_packet(1'b0, 2'b10, data, (i % 2 == 0) ? ~^data[4:0] : ^data[4:0], -1);
        end

        test_name = "tap2_dr_write";
        chain_ir_i       = IR_DMI;
        dmi_short_mode_i = 1'b1;
        data             = {$urandom, $urandom};
        send_packet(1'b0, 2'b11, data, ~^data[33:0], -1);

        test_name = "tap2_dr_read";
        read_dr(IR_IDCODE, 1'b0);
        read_dr(IR_DMI, 1'b1);
        read_dr(IR_DMI, 1'b0);
        read_dr(IR_DMI_ACC, 1'b0);
        read_dr(IR_DTMCS, 1'b0);
        read_dr(5'h07, 1'b0);

        test_name = "hard_reset";
        chain_ir_i       = IR_DMI;
        dmi_short_mode_i = 1'b0;
        send_packet(1'b1, 2'b11, {$urandom, $urandom}, 1'b0, 12);
        repeat (3) drive_cycle(1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
        send_packet(1'b1, 2'b11, {$urandom, $urandom}, 1'b1, -1);

        // these TMS bits would walk a live TAP into shift-dr
        test_name = "mode_exclusion";
        send_packet(1'b1, 2'b00, 64'h0, 1'b0, -1);
        walk_tap5(40);

        @(posedge tclk);
        #1;
        $display("cycles checked: %0d, errors: %0d", checked_cnt, err_cnt);
        if (err_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/dtm_ctrl_top.sv ====
/*
 * debug transport control core
 *   four-wire TAP controller
 *   two-wire sequencer and framing pair
 *   merged chain strobes
 */
`timescale 1ns/1ps
`default_nettype none

module dtm_ctrl_top
    import dtm_pkg::*;
(
    input  wire                tclk,
    input  wire                trst_b,
    input  wire                dmi_hard_reset_i,
    input  wire                tap_en_i,
    input  wire                jtag2_sel_i,      // 1 = two-wire
    input  wire                tms_i,
    input  wire                dmi_short_mode_i,
    input  wire [IR_WIDTH-1:0] chain_ir_i,
    output logic               tdo_en_o,
    output logic               tms_oe_o,
    output chain_ctrl_t        chain_ctrl_o,
    output logic               shift_par_o,
    output logic               shift_sync_o
);

    chain_ctrl_t          tap5_ctrl;
    chain_ctrl_t          tap2_ctrl;
    tap2_phase_t          tap2_phase;
    logic                 tap2_read;
    logic [LEN_WIDTH-1:0] tap2_len;

    tap5_fsm u_tap5 (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .jtag2_sel_i      (jtag2_sel_i),
        .tap_en_i         (tap_en_i),
        .tms_i            (tms_i),
        .chain_ctrl_o     (tap5_ctrl),
        .tdo_en_o         (tdo_en_o)
    );

    tap2_sequencer u_tap2_seq (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .jtag2_sel_i      (jtag2_sel_i),
        .tap_en_i         (tap_en_i),
        .tms_i            (tms_i),
        .read_i           (tap2_read),
        .data_len_i       (tap2_len),
        .phase_o          (tap2_phase)
    );

    tap2_frame u_tap2_frame (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .tms_i            (tms_i),
        .dmi_short_mode_i (dmi_short_mode_i),
        .chain_ir_i       (chain_ir_i),
        .phase_i          (tap2_phase),
        .read_o           (tap2_read),
        .data_len_o       (tap2_len),
        .tms_oe_o         (tms_oe_o),
        .chain_ctrl_o     (tap2_ctrl),
        .shift_par_o      (shift_par_o),
        .shift_sync_o     (shift_sync_o)
    );

    // only one machine is out of reset at a time
    assign chain_ctrl_o = chain_ctrl_t'(tap5_ctrl | tap2_ctrl);

endmodule

`default_nettype wire

// ==== hw/tap2_frame.sv ====
/*
 * two-wire packet framing
 *   read/write bit and register select capture
 *   data length by select, instruction and dmi mode
 *   odd-parity check, TMS output enable
 *   two-wire chain, parity and sync strobes
 */
`timescale 1ns/1ps
`default_nettype none

module tap2_frame
    import dtm_pkg::*;
(
    input  wire                  tclk,
    input  wire                  trst_b,
    input  wire                  dmi_hard_reset_i,
    input  wire                  tms_i,
    input  wire                  dmi_short_mode_i,
    input  wire [IR_WIDTH-1:0]   chain_ir_i,
    input  wire tap2_phase_t     phase_i,
    output logic                 read_o,
    output logic [LEN_WIDTH-1:0] data_len_o,
    output logic                 tms_oe_o,
    output chain_ctrl_t          chain_ctrl_o,
    output logic                 shift_par_o,
    output logic                 shift_sync_o
);

    logic [1:0]           rs_q;       // first select bit ends up in bit 0
    logic                 parity_q;   // low once an odd count of ones is seen
    logic                 ir_sel;
    logic                 dr_sel;
    logic                 wr_ok;
    logic [LEN_WIDTH-1:0] dr_len;

    // ====================
    // packet header
    // ====================
    always_ff @(posedge tclk) begin
        if (phase_i.rw)
            read_o <= tms_i;               // 1 = read
        if (phase_i.rs)
            rs_q <= {tms_i, rs_q[1]};
    end

    assign ir_sel = (rs_q == 2'b10);
    assign dr_sel = (rs_q == 2'b11);

    // dr length depends on the current instruction
    always_comb begin
        case (chain_ir_i)
            IR_DMI_ACC: dr_len = LEN_WIDTH'(DMI_ACC_LEN - 1);
            IR_DMI: begin
                if (dmi_short_mode_i)
                    dr_len = LEN_WIDTH'(DMI_ACC_WIDTH - 1);
                else
                    dr_len = LEN_WIDTH'(DMI_WIDTH - 1);
            end
            IR_IDCODE,
            IR_DTMCS:   dr_len = LEN_WIDTH'(NDMI_WIDTH - 1);
            default:    dr_len = '0;
        endcase
    end

    // unknown select still walks one data cycle
    assign data_len_o = ir_sel ? LEN_WIDTH'(IR_WIDTH - 1) : (dr_sel ? dr_len : '0);

    // ====================
    // parity and tms enable
    // ====================
    always_ff @(posedge tclk) begin
        if (phase_i.rw)
            parity_q <= 1'b1;
        else if (phase_i.data || phase_i.parity)
            parity_q <= parity_q ^ tms_i;  // data bits then the parity bit
    end

    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            tms_oe_o <= 1'b0;
        end else if (dmi_hard_reset_i) begin
            tms_oe_o <= 1'b0;
        end else if (phase_i.trn1 && read_o) begin
            tms_oe_o <= 1'b1;              // target drives the line on reads
        end else if (phase_i.trn2) begin
            tms_oe_o <= 1'b0;
        end
    end

    // ====================
    // strobes
    // ====================
    assign wr_ok = phase_i.trn2 & ~read_o & ~parity_q;

    assign chain_ctrl_o.capture_ir = phase_i.trn1 & read_o & ir_sel;
    assign chain_ctrl_o.capture_dr = phase_i.trn1 & read_o & dr_sel;
    assign chain_ctrl_o.shift_ir   = phase_i.data & ir_sel;
    assign chain_ctrl_o.shift_dr   = phase_i.data & dr_sel;
    assign chain_ctrl_o.update_ir  = wr_ok & ir_sel;
    assign chain_ctrl_o.update_dr  = wr_ok & dr_sel;

    assign shift_par_o  = phase_i.parity;
    assign shift_sync_o = phase_i.sync;

endmodule

`default_nettype wire

// ==== hw/tap2_sequencer.sv ====
/*
 * two-wire packet sequencer
 *   packet state machine on the shared TMS line
 *   select-bit counter for the two rs bits
 *   data-length down counter
 *   phase flags for the framing logic
 */
`timescale 1ns/1ps
`default_nettype none

module tap2_sequencer
    import dtm_pkg::*;
(
    input  wire                 tclk,
    input  wire                 trst_b,
    input  wire                 dmi_hard_reset_i,
    input  wire                 jtag2_sel_i,
    input  wire                 tap_en_i,
    input  wire                 tms_i,
    input  wire                 read_i,
    input  wire [LEN_WIDTH-1:0] data_len_i,
    output tap2_phase_t         phase_o
);

    tap2_state_e          tap2_cur;
    tap2_state_e          tap2_nxt;
    logic [1:0]           rs_cnt;     // select bits still to come, minus one
    logic [LEN_WIDTH-1:0] data_cnt;   // data bits still to come, minus one

    // ====================
    // state register
    // ====================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            tap2_cur <= TAP2_RESET;
        end else if (dmi_hard_reset_i || !jtag2_sel_i) begin
            tap2_cur <= TAP2_RESET;
        end else begin
            tap2_cur <= tap2_nxt;
        end
    end

    always_comb begin
        tap2_nxt = tap2_cur;
        case (tap2_cur)
            TAP2_RESET: begin
                if (tap_en_i && tms_i)
                    tap2_nxt = TAP2_START;
            end
            TAP2_START: begin
                if (!tms_i)                    // start bit
                    tap2_nxt = TAP2_RW;
            end
            TAP2_RW:     tap2_nxt = TAP2_RS;
            TAP2_RS: begin
                if (rs_cnt == 2'd0)
                    tap2_nxt = TAP2_TRN1;
            end
            TAP2_TRN1:   tap2_nxt = read_i ? TAP2_SYNC : TAP2_DATA;
            TAP2_SYNC:   tap2_nxt = TAP2_DATA;
            TAP2_DATA: begin
                if (data_cnt == '0)
                    tap2_nxt = TAP2_PARITY;
            end
            TAP2_PARITY: tap2_nxt = TAP2_TRN2;
            TAP2_TRN2:   tap2_nxt = TAP2_START; // next packet
            default:     tap2_nxt = TAP2_RESET;
        endcase
    end

    // ====================
    // counters
    // ====================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            rs_cnt <= 2'd0;
        end else if (phase_o.rw) begin
            rs_cnt <= 2'd1;
        end else if (phase_o.rs) begin
            rs_cnt <= rs_cnt - 2'd1;
        end
    end

    // length is settled by trn1, the select bits are in by then
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            data_cnt <= '0;
        end else if (phase_o.trn1) begin
            data_cnt <= data_len_i;
        end else if (phase_o.data) begin
            data_cnt <= data_cnt - LEN_WIDTH'(1);
        end
    end

    assign phase_o.rw     = (tap2_cur == TAP2_RW);
    assign phase_o.rs     = (tap2_cur == TAP2_RS);
    assign phase_o.trn1   = (tap2_cur == TAP2_TRN1);
    assign phase_o.sync   = (tap2_cur == TAP2_SYNC);
    assign phase_o.data   = (tap2_cur == TAP2_DATA);
    assign phase_o.parity = (tap2_cur == TAP2_PARITY);
    assign phase_o.trn2   = (tap2_cur == TAP2_TRN2);

endmodule

`default_nettype wire

// ==== hw/tap5_fsm.sv ====
/*
 * four-wire JTAG TAP controller
 *   sixteen-state TAP walk steered by TMS
 *   capture, shift and update strobes decoded from the state
 *   TDO output enable registered on the falling edge
 */
`timescale 1ns/1ps
`default_nettype none

module tap5_fsm
    import dtm_pkg::*;
(
    input  wire         tclk,
    input  wire         trst_b,
    input  wire         dmi_hard_reset_i,
    input  wire         jtag2_sel_i,
    input  wire         tap_en_i,
    input  wire         tms_i,
    output chain_ctrl_t chain_ctrl_o,
    output logic        tdo_en_o
);

    tap5_state_e tap5_cur;
    tap5_state_e tap5_nxt;
    logic        in_shift;

    // ====================
    // state register
    // ====================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            tap5_cur <= TAP5_RESET;
        end else if (dmi_hard_reset_i || jtag2_sel_i) begin
            tap5_cur <= TAP5_RESET;    // two-wire mode owns the pin
        end else begin
            tap5_cur <= tap5_nxt;
        end
    end

    always_comb begin
        case (tap5_cur)
            TAP5_RESET: begin
                // leaving reset also needs the tap enabled
                tap5_nxt = (tap_en_i && !tms_i) ? TAP5_IDLE : TAP5_RESET;
            end
            TAP5_IDLE:      tap5_nxt = tms_i ? TAP5_SEL_DR    : TAP5_IDLE;
            TAP5_SEL_DR:    tap5_nxt = tms_i ? TAP5_SEL_IR    : TAP5_CAPT_DR;
            TAP5_SEL_IR:    tap5_nxt = tms_i ? TAP5_RESET     : TAP5_CAPT_IR;
            TAP5_CAPT_IR:   tap5_nxt = tms_i ? TAP5_EXIT1_IR  : TAP5_SHIFT_IR;
            TAP5_SHIFT_IR:  tap5_nxt = tms_i ? TAP5_EXIT1_IR  : TAP5_SHIFT_IR;
            TAP5_EXIT1_IR:  tap5_nxt = tms_i ? TAP5_UPDATE_IR : TAP5_PAUSE_IR;
            TAP5_PAUSE_IR:  tap5_nxt = tms_i ? TAP5_EXIT2_IR  : TAP5_PAUSE_IR;
            TAP5_EXIT2_IR:  tap5_nxt = tms_i ? TAP5_UPDATE_IR : TAP5_SHIFT_IR;
            TAP5_UPDATE_IR: tap5_nxt = tms_i ? TAP5_SEL_DR    : TAP5_IDLE;
            TAP5_CAPT_DR:   tap5_nxt = tms_i ? TAP5_EXIT1_DR  : TAP5_SHIFT_DR;
            TAP5_SHIFT_DR:  tap5_nxt = tms_i ? TAP5_EXIT1_DR  : TAP5_SHIFT_DR;
            TAP5_EXIT1_DR:  tap5_nxt = tms_i ? TAP5_UPDATE_DR : TAP5_PAUSE_DR;
            TAP5_PAUSE_DR:  tap5_nxt = tms_i ? TAP5_EXIT2_DR  : TAP5_PAUSE_DR;
            TAP5_EXIT2_DR:  tap5_nxt = tms_i ? TAP5_UPDATE_DR : TAP5_SHIFT_DR;
            TAP5_UPDATE_DR: tap5_nxt = tms_i ? TAP5_SEL_DR    : TAP5_IDLE;
            default:        tap5_nxt = TAP5_RESET;
        endcase
    end

    // ====================
    // chain strobes
    // ====================
    assign chain_ctrl_o.capture_ir = (tap5_cur == TAP5_CAPT_IR);
    assign chain_ctrl_o.capture_dr = (tap5_cur == TAP5_CAPT_DR);
    assign chain_ctrl_o.shift_ir   = (tap5_cur == TAP5_SHIFT_IR);
    assign chain_ctrl_o.shift_dr   = (tap5_cur == TAP5_SHIFT_DR);
    assign chain_ctrl_o.update_ir  = (tap5_cur == TAP5_UPDATE_IR);
    assign chain_ctrl_o.update_dr  = (tap5_cur == TAP5_UPDATE_DR);

    assign in_shift = chain_ctrl_o.shift_ir | chain_ctrl_o.shift_dr;

    // tdo driven half a cycle into the shift state, released half a cycle after
    always_ff @(negedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            tdo_en_o <= 1'b0;
        end else if (dmi_hard_reset_i) begin
            tdo_en_o <= 1'b0;
        end else begin
            tdo_en_o <= in_shift;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dtm_pkg.sv ====
/*
 * shared definitions for the debug transport controller
 *   register widths and data-length counter width
 *   instruction codes
 *   four-wire TAP and two-wire sequencer state encodings
 *   chain strobe struct and two-wire phase struct
 */
`default_nettype none

package dtm_pkg;

    // ====================
    // widths
    // ====================
    localparam int IR_WIDTH      = 5;
    localparam int ABITS         = 16;
    localparam int DMI_WIDTH     = ABITS + 34;        // addr + data + op
    localparam int DMI_ACC_WIDTH = DMI_WIDTH - ABITS; // short dmi, no addr
    localparam int NDMI_WIDTH    = 32;                // idcode and dtmcs
    localparam int DMI_ACC_LEN   = 1;
    localparam int LEN_WIDTH     = 8;

    // instruction codes
    localparam logic [IR_WIDTH-1:0] IR_IDCODE  = 5'h01;
    localparam logic [IR_WIDTH-1:0] IR_DMI_ACC = 5'h02;
    localparam logic [IR_WIDTH-1:0] IR_DTMCS   = 5'h10;
    localparam logic [IR_WIDTH-1:0] IR_DMI     = 5'h11;

    // ====================
    // state encodings
    // ====================
    typedef enum logic [3:0] {
        TAP5_RESET     = 4'b0000,
        TAP5_IDLE      = 4'b0001,
        TAP5_SEL_IR    = 4'b0010,
        TAP5_SEL_DR    = 4'b0011,
        TAP5_SHIFT_IR  = 4'b0100,
        TAP5_EXIT1_IR  = 4'b0101,
        TAP5_CAPT_IR   = 4'b0110,
        TAP5_UPDATE_IR = 4'b0111,
        TAP5_EXIT1_DR  = 4'b1000,
        TAP5_UPDATE_DR = 4'b1001,
        TAP5_SHIFT_DR  = 4'b1010,
        TAP5_CAPT_DR   = 4'b1011,
        TAP5_PAUSE_DR  = 4'b1100,
        TAP5_PAUSE_IR  = 4'b1101,
        TAP5_EXIT2_DR  = 4'b1110,
        TAP5_EXIT2_IR  = 4'b1111
    } tap5_state_e;

    typedef enum logic [3:0] {
        TAP2_RESET  = 4'b0000,
        TAP2_START  = 4'b0001,
        TAP2_RW     = 4'b0010,
        TAP2_RS     = 4'b0011,
        TAP2_TRN1   = 4'b0100,
        TAP2_DATA   = 4'b0101,
        TAP2_SYNC   = 4'b0110,
        TAP2_PARITY = 4'b0111,
        TAP2_TRN2   = 4'b1000
    } tap2_state_e;

    // ====================
    // structs
    // ====================
    typedef struct packed {
        logic capture_ir;
        logic capture_dr;
        logic shift_ir;
        logic shift_dr;
        logic update_ir;
        logic update_dr;
    } chain_ctrl_t;

    // one flag per packet phase, high while the sequencer sits in it
    typedef struct packed {
        logic rw;
        logic rs;
        logic trn1;
        logic sync;
        logic data;
        logic parity;
        logic trn2;
    } tap2_phase_t;

endpackage

`default_nettype wire
